/* core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data path and pc width
`define CORE_XLEN    32
`define CORE_NREGS   32
`define CORE_RADDR_W 5
`define CORE_OP_W    4
`define CORE_IMM_W   12

// low bit of each register field, opcode sits at the top
`define CORE_RD_LSB  23
`define CORE_RJ_LSB  18
`define CORE_RK_LSB  13

`endif

/* core_pkg.sv */
`include "core_config.svh"

package core_pkg;

  // opcode encoding, anything else decodes to OP_NOP
  typedef enum logic [`CORE_OP_W-1:0] {
    OP_ADD  = 0,
    OP_SUB  = 1,
    OP_AND  = 2,
    OP_OR   = 3,
    OP_XOR  = 4,
    OP_SLT  = 5,
    OP_SLTU = 6,
    OP_ADDI = 7,
    OP_NOP  = 15
  } alu_op_e;

  // decode to execute
  typedef struct packed {
    alu_op_e                  op;
    logic [`CORE_XLEN-1:0]    a;
    logic [`CORE_XLEN-1:0]    b;
    logic [`CORE_RADDR_W-1:0] rd;
    logic                     wen;
  } dec_pay_t;

  // execute to result
  typedef struct packed {
    logic [`CORE_XLEN-1:0]    res;
    logic [`CORE_RADDR_W-1:0] rd;
    logic                     wen;
  } exe_pay_t;

  // one bypass source
  typedef struct packed {
    logic                     vld;
    logic [`CORE_RADDR_W-1:0] idx;
    logic [`CORE_XLEN-1:0]    val;
  } fwd_t;

endpackage

/* pipe_if.sv */
`timescale 1ns/10ps
`include "core_config.svh"

interface pipe_if #(
  parameter type PAY_T = logic
) ();

  logic                  valid;
  logic                  ready;
  logic [`CORE_XLEN-1:0] pc;
  PAY_T                  pay;

  modport producer (
    output valid, pc, pay,
    input  ready
  );

  modport consumer (
    input  valid, pc, pay,
    output ready
  );

endinterface

/* pipe_slot.sv */
`timescale 1ns/10ps
`include "core_config.svh"

module pipe_slot #(
  parameter type PAY_T = logic
) (
  input  logic     aclk,
  input  logic     i_arst_n,
  pipe_if.consumer s,
  pipe_if.producer m
);

  logic                  full;
  logic                  take;
  logic [`CORE_XLEN-1:0] pc_q;
  PAY_T                  pay_q;

  // free now, or emptied by the consumer on this edge
  assign s.ready = !full || m.ready;
  assign take    = s.valid && s.ready;

  always_ff @(posedge aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      full <= 1'b0;
    end else if (s.ready) begin
      full <= s.valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      pc_q  <= s.pc;
      pay_q <= s.pay;
    end
  end

  assign m.valid = full;
  assign m.pc    = pc_q;
  assign m.pay   = pay_q;

  // a stalled offer must not change under the slot
  a_hold_stable: assert property (
    @(posedge aclk) disable iff (!i_arst_n)
      s.valid && !s.ready |=> s.valid && $stable(s.pc) && $stable(s.pay)
  );

endmodule

/* decode_stage.sv */
`timescale 1ns/10ps
`include "core_config.svh"

module decode_stage (
  input  logic                     aclk,
  input  logic                     i_arst_n,
  input  logic                     i_inst_valid,
  input  logic [`CORE_XLEN-1:0]    i_inst,
  input  logic [`CORE_XLEN-1:0]    i_pc,
  output logic                     o_inst_ready,
  output logic [`CORE_RADDR_W-1:0] o_rs1_idx,
  output logic [`CORE_RADDR_W-1:0] o_rs2_idx,
  input  logic [`CORE_XLEN-1:0]    i_rs1_data,
  input  logic [`CORE_XLEN-1:0]    i_rs2_data,
  input  core_pkg::fwd_t           i_fwd_alu,
  input  core_pkg::fwd_t           i_fwd_exe,
  input  core_pkg::fwd_t           i_fwd_res,
  pipe_if.producer                 m
);

  import core_pkg::*;

  logic [`CORE_OP_W-1:0]    f_op;
  logic [`CORE_RADDR_W-1:0] f_rd;
  logic [`CORE_RADDR_W-1:0] f_rj;
  logic [`CORE_RADDR_W-1:0] f_rk;
  logic [`CORE_IMM_W-1:0]   f_imm;
  logic [`CORE_XLEN-1:0]    imm_ext;
  dec_pay_t                 dec_pay;

  pipe_if #(.PAY_T(dec_pay_t)) dec_in ();

  // youngest matching source wins, r0 is never bypassed
  function automatic logic [`CORE_XLEN-1:0] fwd_pick(
    input logic [`CORE_RADDR_W-1:0] idx,
    input logic [`CORE_XLEN-1:0]    rf_val
  );
    if (idx == '0) begin
      fwd_pick = '0;
    end else if (i_fwd_alu.vld && i_fwd_alu.idx == idx) begin
      fwd_pick = i_fwd_alu.val;
    end else if (i_fwd_exe.vld && i_fwd_exe.idx == idx) begin
      fwd_pick = i_fwd_exe.val;
    end else if (i_fwd_res.vld && i_fwd_res.idx == idx) begin
      fwd_pick = i_fwd_res.val;
    end else begin
      fwd_pick = rf_val;
    end
  endfunction

  assign f_op    = i_inst[`CORE_XLEN-1 -: `CORE_OP_W];
  assign f_rd    = i_inst[`CORE_RD_LSB +: `CORE_RADDR_W];
  assign f_rj    = i_inst[`CORE_RJ_LSB +: `CORE_RADDR_W];
  assign f_rk    = i_inst[`CORE_RK_LSB +: `CORE_RADDR_W];
  assign f_imm   = i_inst[`CORE_IMM_W-1:0];
  assign imm_ext = {{(`CORE_XLEN-`CORE_IMM_W){f_imm[`CORE_IMM_W-1]}}, f_imm};

  assign o_rs1_idx = f_rj;
  assign o_rs2_idx = f_rk;

  always_comb begin
    case (f_op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU, OP_ADDI: begin
        dec_pay.op  = alu_op_e'(f_op);
        dec_pay.wen = (f_rd != '0);
      end
      default: begin
        dec_pay.op  = OP_NOP;
        dec_pay.wen = 1'b0;
      end
    endcase
    dec_pay.rd = f_rd;
    dec_pay.a  = fwd_pick(f_rj, i_rs1_data);
    // ADDI takes the immediate in place of rk
    if (f_op == OP_ADDI) begin
      dec_pay.b = imm_ext;
    end else begin
      dec_pay.b = fwd_pick(f_rk, i_rs2_data);
    end
  end

  assign dec_in.valid = i_inst_valid;
  assign dec_in.pc    = i_pc;
  assign dec_in.pay   = dec_pay;
  assign o_inst_ready = dec_in.ready;

  pipe_slot #(.PAY_T(dec_pay_t)) u_dec_slot (
    .aclk     (aclk),
    .i_arst_n (i_arst_n),
    .s        (dec_in),
    .m        (m)
  );

endmodule

/* execute_stage.sv */
`timescale 1ns/10ps
`include "core_config.svh"

module execute_stage (
  input  logic           aclk,
  input  logic           i_arst_n,
  pipe_if.consumer       s,
  pipe_if.producer       m,
  output core_pkg::fwd_t o_fwd_alu,
  output core_pkg::fwd_t o_fwd_exe
);

  import core_pkg::*;

  logic [`CORE_XLEN-1:0] alu_res;
  exe_pay_t              exe_pay;

  pipe_if #(.PAY_T(exe_pay_t)) exe_in ();

  always_comb begin
    case (s.pay.op)
      OP_ADD, OP_ADDI: alu_res = s.pay.a + s.pay.b;
      OP_SUB:          alu_res = s.pay.a - s.pay.b;
      OP_AND:          alu_res = s.pay.a & s.pay.b;
      OP_OR:           alu_res = s.pay.a | s.pay.b;
      OP_XOR:          alu_res = s.pay.a ^ s.pay.b;
      OP_SLT: begin
        alu_res = {{(`CORE_XLEN-1){1'b0}}, $signed(s.pay.a) < $signed(s.pay.b)};
      end
      OP_SLTU: begin
        alu_res = {{(`CORE_XLEN-1){1'b0}}, s.pay.a < s.pay.b};
      end
      default:         alu_res = '0;
    endcase
  end

  assign exe_pay.res = alu_res;
  assign exe_pay.rd  = s.pay.rd;
  assign exe_pay.wen = s.pay.wen;

  assign exe_in.valid = s.valid;
  assign exe_in.pc    = s.pc;
  assign exe_in.pay   = exe_pay;
  assign s.ready      = exe_in.ready;

  pipe_slot #(.PAY_T(exe_pay_t)) u_exe_slot (
    .aclk     (aclk),
    .i_arst_n (i_arst_n),
    .s        (exe_in),
    .m        (m)
  );

  // bypass from the alu and from the slot behind it
  assign o_fwd_alu.vld = s.valid && s.pay.wen;
  assign o_fwd_alu.idx = s.pay.rd;
  assign o_fwd_alu.val = alu_res;

  assign o_fwd_exe.vld = m.valid && m.pay.wen;
  assign o_fwd_exe.idx = m.pay.rd;
  assign o_fwd_exe.val = m.pay.res;

endmodule

/* result_stage.sv */
`timescale 1ns/10ps
`include "core_config.svh"

module result_stage (
  input  logic                     aclk,
  input  logic                     i_arst_n,
  pipe_if.consumer                 s,
  input  logic [`CORE_RADDR_W-1:0] i_rs1_idx,
  input  logic [`CORE_RADDR_W-1:0] i_rs2_idx,
  output logic [`CORE_XLEN-1:0]    o_rs1_data,
  output logic [`CORE_XLEN-1:0]    o_rs2_data,
  output core_pkg::fwd_t           o_fwd_res,
  input  logic                     i_wb_ready,
  output logic                     o_wb_valid,
  output logic [`CORE_XLEN-1:0]    o_wb_pc,
  output logic                     o_wb_rf_wen,
  output logic [`CORE_RADDR_W-1:0] o_wb_rf_wnum,
  output logic [`CORE_XLEN-1:0]    o_wb_rf_wdata
);

  logic [`CORE_XLEN-1:0] rf_q [`CORE_NREGS];
  logic                  retire;

  // writeback consumer is the only back-pressure source
  assign s.ready = i_wb_ready;
  assign retire  = s.valid && i_wb_ready;

  assign o_wb_valid    = s.valid;
  assign o_wb_pc       = s.pc;
  assign o_wb_rf_wen   = s.pay.wen;
  assign o_wb_rf_wnum  = s.pay.rd;
  assign o_wb_rf_wdata = s.pay.res;

  // registers come up as zero
  always_ff @(posedge aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < `CORE_NREGS; i++) begin
        rf_q[i] <= '0;
      end
    end else if (retire && s.pay.wen) begin
      rf_q[s.pay.rd] <= s.pay.res;
    end
  end

  assign o_rs1_data = (i_rs1_idx == '0) ? '0 : rf_q[i_rs1_idx];
  assign o_rs2_data = (i_rs2_idx == '0) ? '0 : rf_q[i_rs2_idx];

  // retiring entry, not yet visible in rf_q
  assign o_fwd_res.vld = s.valid && s.pay.wen;
  assign o_fwd_res.idx = s.pay.rd;
  assign o_fwd_res.val = s.pay.res;

  // decode must have cleared the write flag for rd of zero
  a_no_r0_write: assert property (
    @(posedge aclk) disable iff (!i_arst_n)
      retire && s.pay.wen |-> s.pay.rd != '0
  );

endmodule

/* core_top.sv */
`timescale 1ns/10ps
`include "core_config.svh"

module core_top (
  input  logic                     aclk,
  input  logic                     i_arst_n,
  input  logic                     i_inst_valid,
  input  logic [`CORE_XLEN-1:0]    i_inst,
  input  logic [`CORE_XLEN-1:0]    i_pc,
  output logic                     o_inst_ready,
  input  logic                     i_wb_ready,
  output logic                     o_wb_valid,
  output logic [`CORE_XLEN-1:0]    o_wb_pc,
  output logic                     o_wb_rf_wen,
  output logic [`CORE_RADDR_W-1:0] o_wb_rf_wnum,
  output logic [`CORE_XLEN-1:0]    o_wb_rf_wdata
);

  import core_pkg::*;

  logic [`CORE_RADDR_W-1:0] rs1_idx;
  logic [`CORE_RADDR_W-1:0] rs2_idx;
  logic [`CORE_XLEN-1:0]    rs1_data;
  logic [`CORE_XLEN-1:0]    rs2_data;
  fwd_t                     fwd_alu;
  fwd_t                     fwd_exe;
  fwd_t                     fwd_res;

  pipe_if #(.PAY_T(dec_pay_t)) dec_to_exe ();
  pipe_if #(.PAY_T(exe_pay_t)) exe_to_res ();

  decode_stage u_decode (
    .aclk         (aclk),
    .i_arst_n     (i_arst_n),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .i_pc         (i_pc),
    .o_inst_ready (o_inst_ready),
    .o_rs1_idx    (rs1_idx),
    .o_rs2_idx    (rs2_idx),
    .i_rs1_data   (rs1_data),
    .i_rs2_data   (rs2_data),
    .i_fwd_alu    (fwd_alu),
    .i_fwd_exe    (fwd_exe),
    .i_fwd_res    (fwd_res),
    .m            (dec_to_exe)
  );

  execute_stage u_execute (
    .aclk      (aclk),
    .i_arst_n  (i_arst_n),
    .s         (dec_to_exe),
    .m         (exe_to_res),
    .o_fwd_alu (fwd_alu),
    .o_fwd_exe (fwd_exe)
  );

  result_stage u_result (
    .aclk          (aclk),
    .i_arst_n      (i_arst_n),
    .s             (exe_to_res),
    .i_rs1_idx     (rs1_idx),
    .i_rs2_idx     (rs2_idx),
    .o_rs1_data    (rs1_data),
    .o_rs2_data    (rs2_data),
    .o_fwd_res     (fwd_res),
    .i_wb_ready    (i_wb_ready),
    .o_wb_valid    (o_wb_valid),
    .o_wb_pc       (o_wb_pc),
    .o_wb_rf_wen   (o_wb_rf_wen),
    .o_wb_rf_wnum  (o_wb_rf_wnum),
    .o_wb_rf_wdata (o_wb_rf_wdata)
  );

endmodule

/* tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
  output logic o_aclk,
  output logic o_arst_n
);

  // 20 ns period
  initial begin
    o_aclk = 1'b0;
    forever #10 o_aclk = ~o_aclk;
  end

  initial begin
    o_arst_n = 1'b0;
    repeat (5) @(posedge o_aclk);
    o_arst_n <= 1'b1;
  end

endmodule

/* tb_core_top.sv */
`timescale 1ns/10ps

module tb_core_top;

  localparam int TOTAL_INSTS = 227;
  localparam logic [3:0] OPC_ADD  = 4'd0;
  localparam logic [3:0] OPC_SUB  = 4'd1;
  localparam logic [3:0] OPC_AND  = 4'd2;
  localparam logic [3:0] OPC_OR   = 4'd3;
  localparam logic [3:0] OPC_XOR  = 4'd4;
  localparam logic [3:0] OPC_SLT  = 4'd5;
  localparam logic [3:0] OPC_SLTU = 4'd6;
  localparam logic [3:0] OPC_ADDI = 4'd7;
  localparam logic [3:0] OPC_UNK  = 4'd9;

  typedef struct packed {
    logic [31:0] pc;
    logic        wen;
    logic [4:0]  rd;
    logic [31:0] data;
  } retire_t;

  logic        aclk;
  logic        arst_n;
  logic        i_inst_valid;
  logic [31:0] i_inst;
  logic [31:0] i_pc;
  logic        i_wb_ready;
  logic        o_inst_ready;
  logic        o_wb_valid;
  logic [31:0] o_wb_pc;
  logic        o_wb_rf_wen;
  logic [4:0]  o_wb_rf_wnum;
  logic [31:0] o_wb_rf_wdata;

  logic [31:0] exp_rf [32];
  retire_t     exp_q [$];
  retire_t     head;
  logic [31:0] next_pc;
  logic        stream_done;
  int          err_cnt;
  int          retired_cnt;
  int          tests_done;

  tb_clock u_clock (
    .o_aclk   (aclk),
    .o_arst_n (arst_n)
  );

  core_top UUT (
    .aclk          (aclk),
    .i_arst_n      (arst_n),
    .i_inst_valid  (i_inst_valid),
    .i_inst        (i_inst),
    .i_pc          (i_pc),
    .o_inst_ready  (o_inst_ready),
    .i_wb_ready    (i_wb_ready),
    .o_wb_valid    (o_wb_valid),
    .o_wb_pc       (o_wb_pc),
    .o_wb_rf_wen   (o_wb_rf_wen),
    .o_wb_rf_wnum  (o_wb_rf_wnum),
    .o_wb_rf_wdata (o_wb_rf_wdata)
  );

  function automatic logic [31:0] encode_inst(input logic [3:0] op, input logic [4:0] rd,
                                              input logic [4:0] rj, input logic [4:0] rk,
                                              input logic [11:0] imm);
    return {op, rd, rj, rk, 1'b0, imm};
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("error at %0d ns: %s expected %h actual %h", $time, name, exp_val, act_val);
    err_cnt++;
  endtask

  task automatic report_problem(input string msg);
    $display("error at %0d ns: %s", $time, msg);
    err_cnt++;
  endtask

  // expected result straight from the ISA rules, in program order
  task automatic predict_retire(input logic [31:0] inst, input logic [31:0] pc);
    logic [3:0]  op;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] res;
    logic        known;
    retire_t     ent;
    op    = inst[31:28];
    rd    = inst[27:23];
    a     = exp_rf[inst[22:18]];
    b     = exp_rf[inst[17:13]];
    imm   = {{20{inst[11]}}, inst[11:0]};
    known = 1'b1;
    case (op)
      OPC_ADD:  res = a + b;
      OPC_SUB:  res = a - b;
      OPC_AND:  res = a & b;
      OPC_OR:   res = a | b;
      OPC_XOR:  res = a ^ b;
      OPC_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OPC_SLTU: res = (a < b) ? 32'd1 : 32'd0;
      OPC_ADDI: res = a + imm;
      default: begin
        res   = '0;
        known = 1'b0;
      end
    endcase
    ent.pc   = pc;
    ent.wen  = known && (rd != 5'd0);
    ent.rd   = rd;
    ent.data = res;
    if (ent.wen) begin
      exp_rf[rd] = res;
    end
    exp_q.push_back(ent);
  endtask

  task automatic offer_inst(input logic [31:0] inst);
    @(posedge aclk);
    i_inst_valid <= 1'b1;
    i_inst       <= inst;
    i_pc         <= next_pc;
  endtask

  // transfer happens on the next rising edge
  task automatic wait_accept();
    @(negedge aclk);
    while (!o_inst_ready) begin
      @(negedge aclk);
    end
    predict_retire(i_inst, i_pc);
    next_pc = next_pc + 32'd4;
  endtask

  task automatic send_inst(input logic [31:0] inst);
    offer_inst(inst);
    wait_accept();
  endtask

  task automatic release_input();
    @(posedge aclk);
    i_inst_valid <= 1'b0;
  endtask

  task automatic drain_retires();
    while (exp_q.size() != 0) begin
      @(negedge aclk);
    end
    @(posedge aclk);
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_done++;
    if (err_cnt == err_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, err_cnt - err_before);
    end
  endtask

  function automatic logic [31:0] random_inst();
    return encode_inst(4'($urandom_range(9, 0)), 5'($urandom_range(7, 0)),
                       5'($urandom_range(7, 0)), 5'($urandom_range(7, 0)),
                       12'($urandom()));
  endfunction

  // every writeback handshake is compared with the head of the queue
  always @(negedge aclk) begin
    if (arst_n && o_wb_valid && i_wb_ready) begin
      if (exp_q.size() == 0) begin
        report_problem("writeback seen with no instruction outstanding");
      end else begin
        head = exp_q.pop_front();
        retired_cnt++;
        if (o_wb_pc !== head.pc)
          report_mismatch("o_wb_pc", head.pc, o_wb_pc);
        if (o_wb_rf_wen !== head.wen)
          report_mismatch("o_wb_rf_wen", 32'(head.wen), 32'(o_wb_rf_wen));
        if (head.wen && o_wb_rf_wnum !== head.rd)
          report_mismatch("o_wb_rf_wnum", 32'(head.rd), 32'(o_wb_rf_wnum));
        if (head.wen && o_wb_rf_wdata !== head.data)
          report_mismatch("o_wb_rf_wdata", head.data, o_wb_rf_wdata);
      end
    end
  end

  task automatic check_reset_state();
    int err_before;
    err_before = err_cnt;
    @(negedge aclk);
    if (o_wb_valid !== 1'b0)
      report_mismatch("o_wb_valid", 32'd0, 32'(o_wb_valid));
    if (o_inst_ready !== 1'b1)
      report_mismatch("o_inst_ready", 32'd1, 32'(o_inst_ready));
    finish_test("reset state", err_before);
  endtask

  task automatic run_opcode_sweep();
    int err_before;
    err_before = err_cnt;
    send_inst(encode_inst(OPC_ADDI, 5'd1, 5'd0, 5'd0, 12'd100));
    send_inst(encode_inst(OPC_ADDI, 5'd2, 5'd0, 5'd0, 12'hff9));
    send_inst(encode_inst(OPC_ADDI, 5'd3, 5'd0, 5'd0, 12'h7ff));
    send_inst(encode_inst(OPC_ADDI, 5'd4, 5'd0, 5'd0, 12'h800));
    send_inst(encode_inst(OPC_ADD, 5'd5, 5'd1, 5'd2, 12'd0));
    send_inst(encode_inst(OPC_SUB, 5'd6, 5'd2, 5'd1, 12'd0));
    send_inst(encode_inst(OPC_AND, 5'd7, 5'd3, 5'd2, 12'd0));
    send_inst(encode_inst(OPC_OR, 5'd8, 5'd1, 5'd4, 12'd0));
    send_inst(encode_inst(OPC_XOR, 5'd9, 5'd3, 5'd4, 12'd0));
    send_inst(encode_inst(OPC_SLT, 5'd10, 5'd2, 5'd1, 12'd0));
    send_inst(encode_inst(OPC_SLTU, 5'd11, 5'd2, 5'd1, 12'd0));
    release_input();
    drain_retires();
    finish_test("opcode sweep", err_before);
  endtask

  // distances one, two and three back hit alu, slot and register file
  task automatic run_dependent_chain();
    int err_before;
    err_before = err_cnt;
    send_inst(encode_inst(OPC_ADDI, 5'd1, 5'd0, 5'd0, 12'd9));
    send_inst(encode_inst(OPC_ADDI, 5'd2, 5'd1, 5'd0, 12'hffd));
    send_inst(encode_inst(OPC_ADD, 5'd3, 5'd2, 5'd1, 12'd0));
    send_inst(encode_inst(OPC_SUB, 5'd4, 5'd3, 5'd2, 12'd0));
    send_inst(encode_inst(OPC_SLTU, 5'd5, 5'd2, 5'd4, 12'd0));
    send_inst(encode_inst(OPC_XOR, 5'd6, 5'd5, 5'd3, 12'd0));
    send_inst(encode_inst(OPC_OR, 5'd7, 5'd6, 5'd4, 12'd0));
    send_inst(encode_inst(OPC_AND, 5'd8, 5'd7, 5'd6, 12'd0));
    release_input();
    drain_retires();
    finish_test("dependent chain", err_before);
  endtask

  task automatic hold_under_backpressure();
    int          err_before;
    int          waited;
    logic [31:0] hold_pc;
    logic [31:0] hold_data;
    logic [4:0]  hold_rd;
    logic        hold_wen;
    err_before = err_cnt;
    @(posedge aclk);
    i_wb_ready <= 1'b0;
    send_inst(encode_inst(OPC_ADDI, 5'd20, 5'd0, 5'd0, 12'd11));
    send_inst(encode_inst(OPC_ADD, 5'd21, 5'd20, 5'd20, 12'd0));
    offer_inst(encode_inst(OPC_SUB, 5'd22, 5'd21, 5'd20, 12'd0));
    waited = 0;
    @(negedge aclk);
    while (o_inst_ready && waited < 10) begin
      @(negedge aclk);
      waited++;
    end
    if (o_inst_ready)
      report_problem("o_inst_ready stayed high with both slots stalled");
    if (!o_wb_valid)
      report_problem("o_wb_valid low while an instruction waits for writeback");
    hold_pc   = o_wb_pc;
    hold_data = o_wb_rf_wdata;
    hold_rd   = o_wb_rf_wnum;
    hold_wen  = o_wb_rf_wen;
    repeat (6) begin
      @(negedge aclk);
      if (o_wb_valid !== 1'b1)
        report_mismatch("o_wb_valid", 32'd1, 32'(o_wb_valid));
      if (o_wb_pc !== hold_pc)
        report_mismatch("o_wb_pc", hold_pc, o_wb_pc);
      if (o_wb_rf_wdata !== hold_data)
        report_mismatch("o_wb_rf_wdata", hold_data, o_wb_rf_wdata);
      if (o_wb_rf_wnum !== hold_rd)
        report_mismatch("o_wb_rf_wnum", 32'(hold_rd), 32'(o_wb_rf_wnum));
      if (o_wb_rf_wen !== hold_wen)
        report_mismatch("o_wb_rf_wen", 32'(hold_wen), 32'(o_wb_rf_wen));
      if (o_inst_ready !== 1'b0)
        report_mismatch("o_inst_ready", 32'd0, 32'(o_inst_ready));
    end
    @(posedge aclk);
    i_wb_ready <= 1'b1;
    wait_accept();
    release_input();
    drain_retires();
    finish_test("backpressure", err_before);
  endtask

  task automatic retire_without_write();
    int err_before;
    err_before = err_cnt;
    send_inst(encode_inst(OPC_ADDI, 5'd0, 5'd0, 5'd0, 12'd55));
    send_inst(encode_inst(OPC_UNK, 5'd13, 5'd1, 5'd2, 12'd0));
    send_inst(encode_inst(OPC_ADD, 5'd14, 5'd0, 5'd0, 12'd0));
    send_inst(encode_inst(OPC_ADDI, 5'd15, 5'd0, 5'd0, 12'd3));
    send_inst(encode_inst(OPC_OR, 5'd16, 5'd13, 5'd0, 12'd0));
    release_input();
    drain_retires();
    finish_test("r0 and unknown opcode", err_before);
  endtask

  task automatic random_stream();
    int err_before;
    err_before  = err_cnt;
    stream_done = 1'b0;
    fork
      begin
        for (int i = 0; i < 200; i++) begin
          send_inst(random_inst());
        end
        release_input();
        stream_done = 1'b1;
      end
      begin
        while (!stream_done) begin
          @(posedge aclk);
          i_wb_ready <= 1'($urandom_range(1, 0));
        end
      end
    join
    @(posedge aclk);
    i_wb_ready <= 1'b1;
    drain_retires();
    finish_test("random stream", err_before);
  endtask

  initial begin
    void'($urandom(4));
    i_inst_valid = 1'b0;
    i_inst       = '0;
    i_pc         = '0;
    i_wb_ready   = 1'b1;
    next_pc      = 32'h1c00_0000;
    stream_done  = 1'b0;
    err_cnt      = 0;
    retired_cnt  = 0;
    tests_done   = 0;
    for (int i = 0; i < 32; i++) begin
      exp_rf[i] = '0;
    end
    @(posedge arst_n);
    check_reset_state();
    run_opcode_sweep();
    run_dependent_chain();
    hold_under_backpressure();
    retire_without_write();
    random_stream();
    $display("%0d tests, %0d retirements checked, %0d errors",
             tests_done, retired_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // each instruction gets 20 cycles, plus reset and slack
  initial begin
    repeat (TOTAL_INSTS * 20 + 200) @(posedge aclk);
    $display("timeout: the run did not finish in the expected number of cycles");
    $display("Test failed");
    $finish;
  end

endmodule

/* core_top.f */
+incdir+.
core_pkg.sv
pipe_if.sv
pipe_slot.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
core_top.sv
tb_clock.sv
tb_core_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f core_top.f --top-module tb_core_top -o tb_sim &&
  ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "Test passed" &&
  exit 0 || exit 1
